// File: drat_pkg.sv
//----------------------------------------------------------
// DRaT packet protocol definitions
// Packet types, field widths and the fixed header length
// for 16-bit complex sample packets
//----------------------------------------------------------
package drat_pkg;

   //----------------------------------------------------------
   // Packet word layout
   //
   //  63    56 55    48 47  34 33 32 31                  0
   //  | type   | seq id | size | 00  |      flow id      |
   //  |                     time                         |
   //  |    I0    |    Q0    |    I1    |    Q1          |
   //----------------------------------------------------------

   // Header type field
   typedef logic [7:0] pkt_type_t;

   // Normal and end-of-burst 16-bit complex packets
   localparam pkt_type_t PKT_INT16_COMPLEX     = 8'h10;
   localparam pkt_type_t PKT_INT16_COMPLEX_EOB = 8'h11;

   // One I/Q sample, I in the upper half
   typedef logic [31:0] sample_t;

   // One packet word on the output stream
   typedef logic [63:0] word_t;

   // Header fields
   typedef logic [7:0]  seq_id_t;
   typedef logic [13:0] pkt_size_t;
   typedef logic [63:0] timestamp_t;
   typedef logic [31:0] flow_id_t;

   // Header plus time word, counted in 32-bit words
   localparam pkt_size_t HEADER_WORDS32 = 14'd4;

endpackage

// File: packetizer_cfg_pkg.sv
//----------------------------------------------------------
// Packetizer implementation configuration
// Buffer depths, counter widths and FIFO entry layouts
//----------------------------------------------------------
package packetizer_cfg_pkg;

   // Metadata entries, one per buffered packet
   localparam int TIME_FIFO_DEPTH = 16;

   // Sample words, two samples each, so 128 samples max per packet
   localparam int SAMPLE_FIFO_DEPTH = 64;

   // Burst length in samples, zero means endless
   typedef logic [47:0] burst_cnt_t;

   // Time step between packets of one burst
   typedef logic [15:0] time_inc_t;

   // Time FIFO entry, 79 bits
   typedef struct packed {
      logic                   eob;
      drat_pkg::pkt_size_t    size;
      drat_pkg::timestamp_t   time_stamp;
   } pkt_meta_t;

   // Sample FIFO entry, 65 bits
   typedef struct packed {
      logic                   last;
      drat_pkg::word_t        data;
   } sample_entry_t;

endpackage

// File: sync_fifo.sv
//----------------------------------------------------------
// Synchronous FIFO
// Circular buffer of DEPTH entries of any packed payload
// type, head shown while valid, push and pop on one edge
//----------------------------------------------------------
module sync_fifo #(
   parameter int  DEPTH     = 16,
   parameter type payload_t = logic [7:0]
) (
   input  logic     clk,
   input  logic     rst,
   input  logic     push,
   input  payload_t push_data,
   input  logic     pop,
   output logic     not_full,
   output logic     valid,
   output payload_t head
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   payload_t        mem [DEPTH];
   logic [AW-1:0]   wr_ptr;
   logic [AW-1:0]   rd_ptr;
   logic [CW-1:0]   count;
   logic            do_push;
   logic            do_pop;

   // Pointer advance with wrap at DEPTH, not a power of two
   function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
      next_ptr = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Requests qualified by space and content
   assign do_push  = push && not_full;
   assign do_pop   = pop && valid;
   assign not_full = (count != CW'(DEPTH));
   assign valid    = (count != '0);
   assign head     = mem[rd_ptr];

   // Storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_data;
      end
   end

   // Pointers and occupancy
   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (do_pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: sample_packer.sv
//----------------------------------------------------------
// Sample packer, input side of the packetizer
// Pairs samples into words, tracks packet and burst
// position and pushes one metadata entry per packet
//----------------------------------------------------------
module sample_packer (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           enable,
   input  logic                           in_valid,
   input  drat_pkg::sample_t              in_data,
   input  logic                           beat,
   input  drat_pkg::pkt_size_t            packet_size,
   input  packetizer_cfg_pkg::burst_cnt_t burst_size,
   input  drat_pkg::timestamp_t           start_time,
   input  packetizer_cfg_pkg::time_inc_t  time_per_pkt,
   output logic                           meta_push,
   output packetizer_cfg_pkg::pkt_meta_t  meta_entry,
   output logic                           word_push,
   output packetizer_cfg_pkg::sample_entry_t word_entry,
   output logic                           in_quiet
);

   // Packet phase
   // PH_FIRST   waiting for the first sample of a packet
   // PH_SECOND  waiting for the second sample of a pair
   // PH_PAIR    waiting for the first sample of a later pair
   typedef enum logic [1:0] {
      PH_FIRST,
      PH_SECOND,
      PH_PAIR
   } phase_t;

   phase_t                          phase;
   drat_pkg::pkt_size_t             sample_cnt;
   drat_pkg::pkt_size_t             count_now;
   logic                            in_burst;
   packetizer_cfg_pkg::burst_cnt_t  burst_left;
   packetizer_cfg_pkg::burst_cnt_t  burst_rem;
   drat_pkg::sample_t               hold;
   drat_pkg::timestamp_t            pkt_time;
   drat_pkg::timestamp_t            pkt_time_next;
   logic                            take;
   logic                            last_of_burst;
   logic                            end_of_packet;

   // Accepted beat as seen by this side
   assign take = beat && in_valid;

   //----------------------------------------------------------
   // Packet and burst position
   //----------------------------------------------------------

   // Samples in this packet including the current beat
   assign count_now = sample_cnt + 1'b1;

   // First beat of a burst sees the full burst size
   assign burst_rem     = in_burst ? burst_left : burst_size;
   assign last_of_burst = (burst_size != '0) && (burst_rem == 48'd1);
   assign end_of_packet = (count_now >= packet_size) || last_of_burst;

   always_ff @(posedge clk) begin
      if (rst || !enable) begin
         phase      <= PH_FIRST;
         sample_cnt <= '0;
         in_burst   <= 1'b0;
         burst_left <= '0;
      end else if (take) begin
         if (end_of_packet) begin
            phase      <= PH_FIRST;
            sample_cnt <= '0;
         end else begin
            phase      <= (phase == PH_SECOND) ? PH_PAIR : PH_SECOND;
            sample_cnt <= count_now;
         end
         // Burst closes on its last sample, endless bursts never do
         in_burst   <= !last_of_burst;
         burst_left <= burst_rem - 1'b1;
      end
   end

   //----------------------------------------------------------
   // Packet time and pair holding register
   //----------------------------------------------------------

   // New time on the first beat of every packet
   always_comb begin
      pkt_time_next = pkt_time;
      if (phase == PH_FIRST) begin
         pkt_time_next = in_burst ? pkt_time + time_per_pkt : start_time;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         pkt_time <= pkt_time_next;
         hold     <= in_data;
      end
   end

   //----------------------------------------------------------
   // FIFO pushes
   //----------------------------------------------------------

   // Metadata goes in with the packet's last sample
   assign meta_push             = take && end_of_packet;
   assign meta_entry.eob        = last_of_burst;
   assign meta_entry.size       = count_now + drat_pkg::HEADER_WORDS32;
   assign meta_entry.time_stamp = pkt_time_next;

   // Completed pair, or a lone sample that ends the packet
   assign word_push       = take && ((phase == PH_SECOND) || end_of_packet);
   assign word_entry.last = end_of_packet;
   // Earlier sample in the upper half, lone sample duplicated
   assign word_entry.data = (phase == PH_SECOND) ? {hold, in_data} : {in_data, in_data};

   // Between packets and between bursts
   assign in_quiet = (phase == PH_FIRST) && !in_burst;

endmodule

// File: pkt_framer.sv
//----------------------------------------------------------
// Packet framer, output side of the packetizer
// Sends header, time and sample words from the FIFO heads
// and keeps the sequence ID
//----------------------------------------------------------
module pkt_framer (
   input  logic                              clk,
   input  logic                              rst,
   input  logic                              enable,
   input  drat_pkg::flow_id_t                flow_id,
   input  logic                              meta_valid,
   input  packetizer_cfg_pkg::pkt_meta_t     meta_head,
   input  logic                              word_valid,
   input  packetizer_cfg_pkg::sample_entry_t word_head,
   input  logic                              out_ready,
   output logic                              meta_pop,
   output logic                              word_pop,
   output logic                              out_valid,
   output drat_pkg::word_t                   out_data,
   output logic                              out_last,
   output logic                              out_quiet
);

   typedef enum logic [1:0] {
      ST_HEADER,
      ST_TIME,
      ST_SAMPLES,
      ST_DRAIN
   } state_t;

   state_t              state;
   drat_pkg::seq_id_t   seq_id;
   drat_pkg::pkt_type_t pkt_type;
   logic                pkt_eob;
   logic                xfer;

   assign xfer     = out_valid && out_ready;
   assign pkt_type = meta_head.eob ? drat_pkg::PKT_INT16_COMPLEX_EOB
                                   : drat_pkg::PKT_INT16_COMPLEX;

   //----------------------------------------------------------
   // State machine
   //----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_DRAIN;
         pkt_eob <= 1'b0;
      end else begin
         case (state)
            ST_HEADER: begin
               if (meta_valid && out_ready) begin
                  state   <= ST_TIME;
                  pkt_eob <= meta_head.eob;
               end else if (!meta_valid && !enable) begin
                  // Nothing pending and disabled
                  state <= ST_DRAIN;
               end
            end
            ST_TIME: begin
               if (meta_valid && out_ready) begin
                  state <= ST_SAMPLES;
               end
            end
            ST_SAMPLES: begin
               if (word_valid && out_ready && word_head.last) begin
                  state <= enable ? ST_HEADER : ST_DRAIN;
               end
            end
            default: begin
               if (enable) begin
                  state <= ST_HEADER;
               end
            end
         endcase
      end
   end

   //----------------------------------------------------------
   // Sequence ID
   //----------------------------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         seq_id <= '0;
      end else if (!enable && (state != ST_HEADER)) begin
         // Header word holds its ID while offered
         seq_id <= '0;
      end else if (xfer && out_last) begin
         // Packet after an EOB starts the next burst at zero
         seq_id <= pkt_eob ? '0 : seq_id + 1'b1;
      end
   end

   //----------------------------------------------------------
   // Output word mux and FIFO pops
   //----------------------------------------------------------
   always_comb begin
      out_valid = 1'b0;
      out_data  = '0;
      out_last  = 1'b0;
      meta_pop  = 1'b0;
      word_pop  = 1'b0;
      case (state)
         ST_HEADER: begin
            out_valid = meta_valid;
            out_data  = {pkt_type, seq_id, meta_head.size, 2'b00, flow_id};
         end
         ST_TIME: begin
            // Metadata leaves with the time word
            out_valid = meta_valid;
            out_data  = meta_head.time_stamp;
            meta_pop  = meta_valid && out_ready;
         end
         ST_SAMPLES: begin
            out_valid = word_valid;
            out_data  = word_head.data;
            out_last  = word_head.last;
            word_pop  = word_valid && out_ready;
         end
         default: begin
            // Flush both FIFOs
            meta_pop = 1'b1;
            word_pop = 1'b1;
         end
      endcase
   end

   // No packet waiting and none in progress
   assign out_quiet = !meta_valid && !word_valid &&
                      ((state == ST_HEADER) || (state == ST_DRAIN));

endmodule

// File: stream_packetizer.sv
//----------------------------------------------------------
// Stream packetizer top level
// Packs I/Q samples into DRaT packets through a time FIFO
// and a sample FIFO, reports an idle flag
//----------------------------------------------------------
module stream_packetizer (
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           enable,
   input  drat_pkg::timestamp_t           start_time,
   input  drat_pkg::pkt_size_t            packet_size,
   input  drat_pkg::flow_id_t             flow_id,
   input  packetizer_cfg_pkg::time_inc_t  time_per_pkt,
   input  packetizer_cfg_pkg::burst_cnt_t burst_size,
   input  logic                           in_valid,
   input  drat_pkg::sample_t              in_data,
   output logic                           in_ready,
   output logic                           idle,
   output logic                           out_valid,
   output drat_pkg::word_t                out_data,
   output logic                           out_last,
   input  logic                           out_ready
);

   logic                                meta_push;
   packetizer_cfg_pkg::pkt_meta_t       meta_entry;
   logic                                meta_not_full;
   logic                                meta_valid;
   packetizer_cfg_pkg::pkt_meta_t       meta_head;
   logic                                meta_pop;
   logic                                word_push;
   packetizer_cfg_pkg::sample_entry_t   word_entry;
   logic                                word_not_full;
   logic                                word_valid;
   packetizer_cfg_pkg::sample_entry_t   word_head;
   logic                                word_pop;
   logic                                beat;
   logic                                in_quiet;
   logic                                out_quiet;

   // Accept only with room for both a word and a metadata entry
   assign in_ready = enable && meta_not_full && word_not_full;
   assign beat     = in_valid && in_ready;

   sample_packer packer (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .beat         (beat),
      .packet_size  (packet_size),
      .burst_size   (burst_size),
      .start_time   (start_time),
      .time_per_pkt (time_per_pkt),
      .meta_push    (meta_push),
      .meta_entry   (meta_entry),
      .word_push    (word_push),
      .word_entry   (word_entry),
      .in_quiet     (in_quiet)
   );

   // One entry per buffered packet
   sync_fifo #(
      .DEPTH     (packetizer_cfg_pkg::TIME_FIFO_DEPTH),
      .payload_t (packetizer_cfg_pkg::pkt_meta_t)
   ) time_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (meta_push),
      .push_data (meta_entry),
      .pop       (meta_pop),
      .not_full  (meta_not_full),
      .valid     (meta_valid),
      .head      (meta_head)
   );

   // Packet bodies, buffered so a packet leaves at full rate
   sync_fifo #(
      .DEPTH     (packetizer_cfg_pkg::SAMPLE_FIFO_DEPTH),
      .payload_t (packetizer_cfg_pkg::sample_entry_t)
   ) sample_fifo (
      .clk       (clk),
      .rst       (rst),
      .push      (word_push),
      .push_data (word_entry),
      .pop       (word_pop),
      .not_full  (word_not_full),
      .valid     (word_valid),
      .head      (word_head)
   );

   pkt_framer framer (
      .clk        (clk),
      .rst        (rst),
      .enable     (enable),
      .flow_id    (flow_id),
      .meta_valid (meta_valid),
      .meta_head  (meta_head),
      .word_valid (word_valid),
      .word_head  (word_head),
      .out_ready  (out_ready),
      .meta_pop   (meta_pop),
      .word_pop   (word_pop),
      .out_valid  (out_valid),
      .out_data   (out_data),
      .out_last   (out_last),
      .out_quiet  (out_quiet)
   );

   // Idle once disabled and both sides have gone quiet
   always_ff @(posedge clk) begin
      if (rst) begin
         idle <= 1'b1;
      end else begin
         idle <= !enable && in_quiet && out_quiet;
      end
   end

endmodule

// File: stream_packetizer_chk.sv
//----------------------------------------------------------
// Stream protocol checker for the packetizer top level
// Output hold under stall, input gating and idle flag
//----------------------------------------------------------
module stream_packetizer_chk (
   input logic            clk,
   input logic            rst,
   input logic            enable,
   input logic            in_ready,
   input logic            idle,
   input logic            out_valid,
   input logic            out_ready,
   input drat_pkg::word_t out_data,
   input logic            out_last
);

   // Failures seen so far, read by the testbench at the end
   int unsigned fail_count = 0;

   // Stalled word stays put until the sink takes it
   hold_while_stalled: assert property (
      @(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> ($stable(out_data) && $stable(out_last))
   ) else begin
      fail_count++;
      $error("Output word or last flag changed while stalled");
   end

   // No input accepted while disabled
   no_ready_when_disabled: assert property (
      @(posedge clk) disable iff (rst)
      !enable |-> !in_ready
   ) else begin
      fail_count++;
      $error("in_ready high while enable is low");
   end

   // Idle means nothing on the output
   no_output_when_idle: assert property (
      @(posedge clk) disable iff (rst)
      idle |-> !out_valid
   ) else begin
      fail_count++;
      $error("idle high while out_valid is high");
   end

endmodule

// File: tb_clock_gen.sv
//----------------------------------------------------------
// Testbench clock and reset
// Period 10 clock, reset held high for the first 4 cycles
//----------------------------------------------------------
module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // Reset released just after the fourth rising edge
   initial begin
      rst = 1'b1;
      repeat (4) @(posedge clk);
      #1 rst = 1'b0;
   end

endmodule

// File: tb_stream_packetizer.sv
//----------------------------------------------------------
// Testbench for the stream packetizer
// Runs a table of tests, predicts every output word from
// the packet rules and checks each transfer
//----------------------------------------------------------
module tb_stream_packetizer;

   localparam logic [31:0] SEED      = 32'd19459;
   localparam logic [31:0] FLOW      = 32'hC0DE_0A17;
   localparam int          NUM_TESTS = 6;

   typedef struct {
      string       name;
      int          pkt_size;
      longint      burst;
      int          inc;
      logic [63:0] start;
      int          n_samples;
      bit          stall;
   } test_row_t;

   logic                           clk;
   logic                           rst;
   logic                           enable;
   drat_pkg::timestamp_t           start_time;
   drat_pkg::pkt_size_t            packet_size;
   drat_pkg::flow_id_t             flow_id;
   packetizer_cfg_pkg::time_inc_t  time_per_pkt;
   packetizer_cfg_pkg::burst_cnt_t burst_size;
   logic                           in_valid;
   drat_pkg::sample_t              in_data;
   logic                           in_ready;
   logic                           idle;
   logic                           out_valid;
   drat_pkg::word_t                out_data;
   logic                           out_last;
   logic                           out_ready;

   test_row_t   tests [NUM_TESTS];
   logic [31:0] rng;
   logic [31:0] samples [$];
   logic [64:0] exp_q [$];
   string       cur_name;
   int          word_idx;
   int          words_checked;
   int          value_errors;
   int          other_errors;
   int          limit;
   int          cycle_cnt;

   tb_clock_gen clock_gen (
      .clk (clk),
      .rst (rst)
   );

   stream_packetizer UUT (
      .clk          (clk),
      .rst          (rst),
      .enable       (enable),
      .start_time   (start_time),
      .packet_size  (packet_size),
      .flow_id      (flow_id),
      .time_per_pkt (time_per_pkt),
      .burst_size   (burst_size),
      .in_valid     (in_valid),
      .in_data      (in_data),
      .in_ready     (in_ready),
      .idle         (idle),
      .out_valid    (out_valid),
      .out_data     (out_data),
      .out_last     (out_last),
      .out_ready    (out_ready)
   );

   bind stream_packetizer stream_packetizer_chk chk (
      .clk       (clk),
      .rst       (rst),
      .enable    (enable),
      .in_ready  (in_ready),
      .idle      (idle),
      .out_valid (out_valid),
      .out_ready (out_ready),
      .out_data  (out_data),
      .out_last  (out_last)
   );

   // 32-bit xorshift
   function automatic logic [31:0] next_rand();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   //----------------------------------------------------------
   // Reference model
   //----------------------------------------------------------

   // Words of the complete packets in a test, for the timeout
   function automatic int count_words(input test_row_t t);
      int     pos;
      int     cnt;
      int     words;
      longint left;
      pos   = 0;
      words = 0;
      left  = t.burst;
      while (1) begin
         cnt = t.pkt_size;
         if (t.burst != 0 && left <= cnt) begin
            cnt = int'(left);
         end
         if (pos + cnt > t.n_samples) begin
            break;
         end
         words += 2 + (cnt + 1) / 2;
         pos   += cnt;
         if (t.burst != 0) begin
            left = (left == cnt) ? t.burst : left - cnt;
         end
      end
      return words;
   endfunction

   // Expected words of every complete packet, partial tail dropped
   task automatic build_expected(input test_row_t t);
      int          pos;
      int          cnt;
      longint      left;
      bit          eob;
      bit          first;
      logic [7:0]  seq;
      logic [7:0]  ptype;
      logic [63:0] tstamp;
      logic [31:0] s_a;
      logic [31:0] s_b;
      pos    = 0;
      left   = t.burst;
      first  = 1'b1;
      seq    = 8'd0;
      tstamp = '0;
      exp_q.delete();
      while (1) begin
         cnt = t.pkt_size;
         eob = 1'b0;
         // Burst end cuts the packet short
         if (t.burst != 0 && left <= cnt) begin
            cnt = int'(left);
            eob = 1'b1;
         end
         if (pos + cnt > t.n_samples) begin
            break;
         end
         tstamp = first ? t.start : tstamp + 64'(t.inc);
         ptype  = eob ? 8'h11 : 8'h10;
         exp_q.push_back({1'b0, ptype, seq, 14'(cnt + 4), 2'b00, FLOW});
         exp_q.push_back({1'b0, tstamp});
         // Earlier sample high, lone sample duplicated
         for (int i = 0; i < cnt; i += 2) begin
            s_a = samples[pos + i];
            s_b = (i + 1 < cnt) ? samples[pos + i + 1] : s_a;
            exp_q.push_back({(i + 2 >= cnt), s_a, s_b});
         end
         pos += cnt;
         if (t.burst != 0) begin
            left -= cnt;
         end
         if (eob) begin
            left  = t.burst;
            first = 1'b1;
            seq   = 8'd0;
         end else begin
            first = 1'b0;
            seq   = seq + 8'd1;
         end
      end
   endtask

   //----------------------------------------------------------
   // Checks and stimulus
   //----------------------------------------------------------

   // Called at the falling edge, where handshakes are settled
   task automatic check_output();
      logic [64:0] exp;
      if (out_valid && out_ready) begin
         assert (exp_q.size() != 0) else begin
            other_errors++;
            $display("ERROR %s: output word %h appeared with no packet pending",
                     cur_name, out_data);
         end
         if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            words_checked++;
            assert ({out_last, out_data} === exp) else begin
               value_errors++;
               $display("ERROR %s: word %0d expected %h last %b, actual %h last %b",
                        cur_name, word_idx, exp[63:0], exp[64], out_data, out_last);
            end
            word_idx++;
         end
      end
   endtask

   // One cycle of offering a sample while disabled
   task automatic offer_disabled(input bit expect_idle);
      in_valid = 1'b1;
      in_data  = next_rand();
      @(negedge clk);
      assert (!in_ready) else begin
         other_errors++;
         $display("ERROR %s: in_ready high while enable is low", cur_name);
      end
      if (expect_idle) begin
         assert (idle) else begin
            other_errors++;
            $display("ERROR %s: idle dropped while disabled and empty", cur_name);
         end
      end
      check_output();
      @(posedge clk);
      #1;
   endtask

   task automatic run_test(input test_row_t t);
      int          sent;
      logic [31:0] r;
      cur_name = t.name;
      word_idx = 0;
      samples.delete();
      for (int k = 0; k < t.n_samples; k++) begin
         samples.push_back(next_rand());
      end
      build_expected(t);
      @(posedge clk);
      #1;
      packet_size  = drat_pkg::pkt_size_t'(t.pkt_size);
      burst_size   = packetizer_cfg_pkg::burst_cnt_t'(t.burst);
      time_per_pkt = packetizer_cfg_pkg::time_inc_t'(t.inc);
      start_time   = t.start;
      enable       = 1'b1;
      sent         = 0;
      // Stream samples until every expected word has left
      while (sent < t.n_samples || exp_q.size() != 0) begin
         in_valid = (sent < t.n_samples);
         in_data  = '0;
         if (sent < t.n_samples) begin
            in_data = samples[sent];
         end
         r         = next_rand();
         out_ready = t.stall ? r[0] : 1'b1;
         @(negedge clk);
         if (in_valid && in_ready) begin
            sent++;
         end
         check_output();
         @(posedge clk);
         #1;
      end
      // Disable, keep offering, wait for idle
      enable    = 1'b0;
      out_ready = 1'b1;
      repeat (4) offer_disabled(1'b0);
      while (!idle) begin
         offer_disabled(1'b0);
      end
      repeat (3) offer_disabled(1'b1);
      in_valid = 1'b0;
   endtask

   //----------------------------------------------------------
   // Main sequence
   //----------------------------------------------------------
   initial begin
      //                name            pkt burst inc  start                  n   stall
      tests[0] = '{"pack_even",    8, 0,  64, 64'h0000_0001_0000_0000, 24, 1'b0};
      tests[1] = '{"odd_size",     5, 0,   5, 64'h0000_0000_0000_1000, 15, 1'b0};
      tests[2] = '{"burst_eob",    5, 12, 40, 64'h0123_4567_89AB_0000, 24, 1'b0};
      tests[3] = '{"partial_drop", 8, 0,  16, 64'h0000_0000_0000_0200, 20, 1'b0};
      tests[4] = '{"stall_burst",  5, 12, 40, 64'h0123_4567_89AB_0000, 24, 1'b1};
      tests[5] = '{"stall_fill",   4, 0,   3, 64'h0000_00FF_0000_0000, 80, 1'b1};
      rng           = SEED;
      words_checked = 0;
      value_errors  = 0;
      other_errors  = 0;
      limit         = 200;
      for (int i = 0; i < NUM_TESTS; i++) begin
         limit += 4 * count_words(tests[i]);
      end
      enable       = 1'b0;
      start_time   = '0;
      packet_size  = '0;
      flow_id      = FLOW;
      time_per_pkt = '0;
      burst_size   = '0;
      in_valid     = 1'b0;
      in_data      = '0;
      out_ready    = 1'b0;
      // Reset is sampled only from the first rising edge on
      @(posedge clk);
      while (rst) begin
         @(posedge clk);
      end
      for (int i = 0; i < NUM_TESTS; i++) begin
         run_test(tests[i]);
      end
      $display("Words checked %0d, value errors %0d, other errors %0d, assertion failures %0d",
               words_checked, value_errors, other_errors, UUT.chk.fail_count);
      if (value_errors == 0 && other_errors == 0 && UUT.chk.fail_count == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

   // Watchdog, limit set from the table at time zero
   initial begin
      cycle_cnt = 0;
      @(posedge clk);
      while (cycle_cnt < limit) begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the DUT stopped delivering packets", limit);
      $display("Test failed");
      $finish;
   end

endmodule

// File: src.f
drat_pkg.sv
packetizer_cfg_pkg.sv
sync_fifo.sv
sample_packer.sv
pkt_framer.sv
stream_packetizer.sv
stream_packetizer_chk.sv
tb_clock_gen.sv
tb_stream_packetizer.sv
